//--- logic/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// Opcode numbers as seen on the op field
	localparam logic [6:0] OP_BL     = 7'd0;
	localparam logic [6:0] OP_BEQ    = 7'd1;	// First branch, code 0
	localparam logic [6:0] OP_BRA    = 7'd8;	// Last branch, code 12
	localparam logic [6:0] OP_ADD    = 7'd9;	// ALU group start
	localparam logic [6:0] OP_BIS    = 7'd20;	// ALU group end
	localparam logic [6:0] OP_MOV    = 7'd21;
	localparam logic [6:0] OP_SWAP   = 7'd22;
	localparam logic [6:0] OP_SRA    = 7'd23;
	localparam logic [6:0] OP_RRC    = 7'd24;
	localparam logic [6:0] OP_SETPRI = 7'd28;
	localparam logic [6:0] OP_SETCC  = 7'd30;
	localparam logic [6:0] OP_CLRCC  = 7'd31;
	localparam logic [6:0] OP_CEX    = 7'd32;

	// CPU cycle numbers
	localparam logic [3:0] CYC_FETCH  = 4'd1;
	localparam logic [3:0] CYC_PCINC  = 4'd2;
	localparam logic [3:0] CYC_IRLOAD = 4'd3;
	localparam logic [3:0] CYC_DECODE = 4'd4;
	localparam logic [3:0] CYC_EXEC   = 4'd5;
	localparam logic [3:0] CYC_STEP2  = 4'd6;
	localparam logic [3:0] CYC_STEP3  = 4'd7;

	// Bus control words, [6] W/B, [5:4] src, [3:2] dst, [1:0] target
	localparam logic [6:0] BUS_IDLE       = 7'b1111111;	// No transfer
	localparam logic [6:0] BUS_ALU_TO_REG = 7'b0011001;
	localparam logic [6:0] BUS_REG_TO_REG = 7'b0001001;
	localparam logic [6:0] BUS_REG_TO_MAR = 7'b0001000;
	localparam logic [6:0] BUS_MDR_TO_IR  = 7'b0000010;

	// PSW source select
	localparam logic [1:0] PSWSRC_ALU  = 2'b00;
	localparam logic [1:0] PSWSRC_NONE = 2'b11;

	// Bit positions in the enables word
	localparam int EN_ALU     = 15;
	localparam int EN_DECODER = 14;
	localparam int EN_SXT     = 13;

	// Register file numbers
	localparam logic [4:0] REG_LR     = 5'd5;
	localparam logic [4:0] REG_PC     = 5'd7;
	localparam logic [4:0] REG_CONST2 = 5'd10;	// Constant 2 for PC step
	localparam logic [4:0] REG_TEMP   = 5'd16;

	// PSW layout
	localparam int PSW_C      = 0;
	localparam int PSW_Z      = 1;
	localparam int PSW_N      = 2;
	localparam int PSW_SLP    = 3;
	localparam int PSW_V      = 4;
	localparam int PSW_PRI_LO = 5;
	localparam int PSW_PRI_HI = 7;
	localparam logic [15:0] PSW_RESET = 16'h60E0;

	// Sign bit of the offset fed to the sign extender
	localparam logic [4:0] SXT_BIT_BL = 5'd13;
	localparam logic [4:0] SXT_BIT_BR = 5'd10;

endpackage

`default_nettype wire

//--- logic/cond_eval.sv
`default_nettype none

module cond_eval import cu_pkg::*; (
	input  wire [3:0] cond_code,
	input  wire [4:0] flags,
	output logic      cond_true
);

	logic n_ne_v;	// Signed less-than term

	assign n_ne_v = flags[PSW_N] ^ flags[PSW_V];

	always_comb
	begin
		case (cond_code)
			4'd0:    cond_true = flags[PSW_Z];	// EQ
			4'd1:    cond_true = !flags[PSW_Z];	// NE
			4'd2:    cond_true = flags[PSW_C];	// CS / HS
			4'd3:    cond_true = !flags[PSW_C];	// CC / LO
			4'd4:    cond_true = flags[PSW_N];	// MI
			4'd5:    cond_true = !flags[PSW_N];	// PL
			4'd6:    cond_true = flags[PSW_V];	// VS
			4'd7:    cond_true = !flags[PSW_V];	// VC
			4'd8:    cond_true = flags[PSW_C] && !flags[PSW_Z];	// HI
			4'd9:    cond_true = !flags[PSW_C] || flags[PSW_Z];	// LS
			4'd10:   cond_true = !n_ne_v;	// GE
			4'd11:   cond_true = n_ne_v;	// LT
			4'd12:   cond_true = !flags[PSW_Z] && !n_ne_v;	// GT
			4'd13:   cond_true = flags[PSW_Z] || n_ne_v;	// LE
			4'd14:   cond_true = 1'b1;	// AL
			default: cond_true = 1'b0;	// Code 15 never holds
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cex_tracker.sv
`default_nettype none

module cex_tracker import cu_pkg::*; #(
	parameter int CNT_W = 3
) (
	input  wire             clock,
	input  wire             cpucycle_rst,
	input  wire [3:0]       cycle_step,
	input  wire             cex_load,
	input  wire             cond_true,
	input  wire [CNT_W-1:0] true_cnt,
	input  wire [CNT_W-1:0] false_cnt,
	output logic            instr_active
);

	logic             cex_on;	// CEX block in progress
	logic             cex_res;	// Condition result latched at CEX
	logic [CNT_W-1:0] t_cnt;	// Remaining true-block instructions
	logic [CNT_W-1:0] f_cnt;	// Remaining false-block instructions
	logic             run_now;	// Decision for the instruction in decode
	logic             run_q;	// Decision held for the execute steps
	logic             last_one;	// Only one instruction left in the block

	// True block comes first, then the false block
	always_comb
	begin
		if (!cex_on)
			run_now = 1'b1;
		else if (t_cnt != '0)
			run_now = cex_res;
		else
			run_now = !cex_res;
	end

	assign last_one = (t_cnt == CNT_W'(1) && f_cnt == '0) ||
		(t_cnt == '0 && f_cnt == CNT_W'(1));

	// Live in decode, held value once the counts have moved
	assign instr_active = (cycle_step == CYC_DECODE) ? run_now : run_q;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			cex_on <= 1'b0;
			run_q  <= 1'b1;
		end
		else if (cex_load)
		begin
			cex_on  <= (true_cnt != '0) || (false_cnt != '0);	// Empty CEX stays off
			cex_res <= cond_true;
			t_cnt   <= true_cnt;
			f_cnt   <= false_cnt;
		end
		else if (cycle_step == CYC_DECODE)
		begin
			run_q <= run_now;
			if (cex_on)
			begin
				if (t_cnt != '0)
					t_cnt <= t_cnt - 1'b1;
				else
					f_cnt <= f_cnt - 1'b1;
				if (last_one)
					cex_on <= 1'b0;	// Block done
			end
		end
	end

	// The false count is only touched once the true count is spent
	a_no_underflow: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(cex_on && !cex_load && cycle_step == CYC_DECODE && t_cnt == '0) |-> (f_cnt != '0));

endmodule

`default_nettype wire

//--- logic/cycle_sequencer.sv
`default_nettype none

module cycle_sequencer import cu_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  wire       clock,
	input  wire       cpucycle_rst,
	input  wire       cycle_restart,
	input  wire       halt,
	output logic [3:0] cycle_step
);

	// The fetch sequence steps the PC by the constant 2, one 16-bit word
	if (DATA_W != 16)
	begin : g_word_chk
		$error("cycle_sequencer expects a 16-bit word machine, DATA_W is %0d", DATA_W);
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			cycle_step <= CYC_FETCH;
		else if (halt)
			cycle_step <= cycle_step;	// Frozen at breakpoint
		else if (cycle_restart)
			cycle_step <= CYC_FETCH;	// Last step of the instruction
		else
			cycle_step <= cycle_step + 4'd1;
	end

	// Relies on exec_ctrl restarting every instruction by its last step
	a_step_range: assert property (@(posedge clock) disable iff (cpucycle_rst)
		cycle_step inside {[CYC_FETCH:CYC_STEP3]});

endmodule

`default_nettype wire

//--- logic/exec_ctrl.sv
`default_nettype none

module exec_ctrl import cu_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  wire              clock,
	input  wire              cpucycle_rst,
	input  wire [3:0]        cycle_step,
	input  wire              halt,
	input  wire [6:0]        op,
	input  wire [3:0]        cond_c,
	input  wire [2:0]        pr,
	input  wire [4:0]        pswb,
	input  wire [2:0]        dst,
	input  wire [2:0]        srccon,
	input  wire              wb,
	input  wire              rc,
	input  wire              instr_active,
	input  wire              cond_true,
	output logic [3:0]       cond_code,
	output logic             cycle_restart,
	output logic             cex_load,
	output logic             flag_set,
	output logic             flag_clr,
	output logic             pri_write,
	output logic             psw_reload,
	output logic [4:0]       mask,
	output logic [2:0]       pri_val,
	output logic [DATA_W-1:0] enables,
	output logic [6:0]       data_bus_ctrl,
	output logic [6:0]       addr_bus_ctrl,
	output logic [1:0]       psw_bus_ctrl,
	output logic             s_bus_ctrl,
	output logic             sxt_bus_ctrl,
	output logic [4:0]       sxt_bit_num,
	output logic             psw_update,
	output logic [5:0]       alu_op,
	output logic [4:0]       dbus_rnum_dst,
	output logic [4:0]       dbus_rnum_src,
	output logic [4:0]       alu_rnum_dst,
	output logic [4:0]       alu_rnum_src,
	output logic [4:0]       addr_rnum_src
);

	localparam logic [6:0] ALU_SHIFT_BASE = 7'd14;	// ALU op slot of SRA

	logic exec_live;	// Active instruction in its first execute step

	assign exec_live = !halt && instr_active && (cycle_step == CYC_EXEC);

	// Branch opcode to condition code, CEX takes its own field
	always_comb
	begin
		case (op) inside
			[OP_BEQ:OP_BEQ + 7'd4]: cond_code = 4'(op - OP_BEQ);	// EQ to MI
			[OP_BEQ + 7'd5:OP_BRA]: cond_code = 4'(op + 7'd4);	// GE to GT
			default:                cond_code = cond_c;
		endcase
	end

	// Ends the instruction on its last step
	always_comb
	begin
		cycle_restart = 1'b0;
		if (!halt)
		begin
			case (cycle_step)
				CYC_EXEC:  cycle_restart = !(instr_active && (op == OP_BL || op == OP_SWAP));
				CYC_STEP2: cycle_restart = (op == OP_BL);
				CYC_STEP3: cycle_restart = 1'b1;
				default:   cycle_restart = 1'b0;
			endcase
		end
	end

	assign cex_load   = exec_live && (op == OP_CEX);
	assign flag_set   = exec_live && (op == OP_SETCC);
	assign flag_clr   = exec_live && (op == OP_CLRCC);
	assign pri_write  = exec_live && (op == OP_SETPRI);
	assign mask       = pswb;
	assign pri_val    = pr;
	assign psw_reload = psw_update && (psw_bus_ctrl == PSWSRC_ALU);	// ALU flags are ready now

	always_ff @(posedge clock)
	begin
		enables       <= '0;	// Idle words every cycle
		data_bus_ctrl <= BUS_IDLE;
		addr_bus_ctrl <= BUS_IDLE;
		psw_bus_ctrl  <= PSWSRC_NONE;
		s_bus_ctrl    <= 1'b0;
		sxt_bus_ctrl  <= 1'b0;
		sxt_bit_num   <= 5'd0;
		psw_update    <= 1'b0;
		alu_op        <= 6'd0;
		dbus_rnum_dst <= 5'd0;
		dbus_rnum_src <= 5'd0;
		alu_rnum_dst  <= 5'd0;
		alu_rnum_src  <= 5'd0;
		addr_rnum_src <= 5'd0;
		if (!cpucycle_rst && !halt)
		begin
			case (cycle_step)
				CYC_FETCH:
				begin
					addr_rnum_src <= REG_PC;	// PC to MAR, memory read starts
					addr_bus_ctrl <= BUS_REG_TO_MAR;
				end
				CYC_PCINC:
				begin
					enables[EN_ALU] <= 1'b1;	// PC + 2
					alu_rnum_dst    <= REG_PC;
					alu_rnum_src    <= REG_CONST2;
					dbus_rnum_dst   <= REG_PC;
					data_bus_ctrl   <= BUS_ALU_TO_REG;
				end
				CYC_IRLOAD:
					data_bus_ctrl <= BUS_MDR_TO_IR;
				CYC_DECODE:
					enables[EN_DECODER] <= instr_active;	// Skipped instructions stay undecoded
				CYC_EXEC:
				begin
					if (instr_active)
					begin
						case (op) inside
							OP_BL:
							begin
								dbus_rnum_dst <= REG_LR;	// LR <= PC first
								dbus_rnum_src <= REG_PC;
								data_bus_ctrl <= BUS_REG_TO_REG;
							end
							[OP_BEQ:OP_BRA]:
							begin
								if (cond_true)
								begin
									enables[EN_ALU] <= 1'b1;	// PC + offset
									enables[EN_SXT] <= 1'b1;
									sxt_bit_num     <= SXT_BIT_BR;
									sxt_bus_ctrl    <= 1'b1;
									s_bus_ctrl      <= 1'b1;
									alu_rnum_dst    <= REG_PC;
									dbus_rnum_dst   <= REG_PC;
									data_bus_ctrl   <= BUS_ALU_TO_REG;
								end
							end
							[OP_ADD:OP_BIS], OP_SRA, OP_RRC:
							begin
								enables[EN_ALU] <= 1'b1;
								psw_update      <= 1'b1;	// Flags come back on psw_in
								psw_bus_ctrl    <= PSWSRC_ALU;
								alu_rnum_dst    <= {2'b00, dst};
								alu_rnum_src    <= {1'b0, rc, srccon};	// rc picks the constant bank
								dbus_rnum_dst   <= {2'b00, dst};
								data_bus_ctrl   <= {wb, BUS_ALU_TO_REG[5:0]};
								if (op == OP_SRA || op == OP_RRC)
									alu_op <= {5'(op - OP_SRA + ALU_SHIFT_BASE), wb};
								else
									alu_op <= {5'(op - OP_ADD), wb};
							end
							OP_MOV:
							begin
								dbus_rnum_dst <= {2'b00, dst};
								dbus_rnum_src <= {2'b00, srccon};
								data_bus_ctrl <= {wb, BUS_REG_TO_REG[5:0]};
							end
							OP_SWAP:
							begin
								dbus_rnum_dst <= REG_TEMP;	// Temp <= src
								dbus_rnum_src <= {2'b00, srccon};
								data_bus_ctrl <= BUS_REG_TO_REG;
							end
							default:
								enables <= '0;	// PSW ops and CEX act through strobes
						endcase
					end
				end
				CYC_STEP2:
				begin
					if (instr_active && op == OP_BL)
					begin
						enables[EN_ALU] <= 1'b1;	// PC <= PC + offset
						enables[EN_SXT] <= 1'b1;
						sxt_bit_num     <= SXT_BIT_BL;
						sxt_bus_ctrl    <= 1'b1;
						s_bus_ctrl      <= 1'b1;
						alu_rnum_dst    <= REG_PC;
						dbus_rnum_dst   <= REG_PC;
						data_bus_ctrl   <= BUS_ALU_TO_REG;
					end
					else if (instr_active && op == OP_SWAP)
					begin
						dbus_rnum_dst <= {2'b00, srccon};	// src <= dst
						dbus_rnum_src <= {2'b00, dst};
						data_bus_ctrl <= BUS_REG_TO_REG;
					end
				end
				CYC_STEP3:
				begin
					if (instr_active && op == OP_SWAP)
					begin
						dbus_rnum_dst <= {2'b00, dst};	// dst <= temp
						dbus_rnum_src <= REG_TEMP;
						data_bus_ctrl <= BUS_REG_TO_REG;
					end
				end
				default:
					enables <= '0;
			endcase
		end
	end

	// Decoder never runs alongside the ALU or sign extender
	a_enable_excl: assert property (@(posedge clock) disable iff (cpucycle_rst)
		$onehot0({enables[EN_DECODER], enables[EN_ALU] | enables[EN_SXT]}));

endmodule

`default_nettype wire

//--- logic/psw_reg.sv
`default_nettype none

module psw_reg import cu_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  wire              clock,
	input  wire              cpucycle_rst,
	input  wire              halt,
	input  wire [DATA_W-1:0] psw_in,
	input  wire              psw_reload,
	input  wire              flag_set,
	input  wire              flag_clr,
	input  wire [4:0]        mask,
	input  wire              pri_write,
	input  wire [2:0]        pri_val,
	output logic [DATA_W-1:0] psw_out
);

	logic [2:0] pri_cur;	// Current priority field

	assign pri_cur = psw_out[PSW_PRI_HI:PSW_PRI_LO];

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw_out <= DATA_W'(PSW_RESET);
		else
		begin
			if (psw_reload)
				psw_out <= psw_in;	// Flags from the ALU step
			if (flag_set)
				psw_out[PSW_V:PSW_C] <= psw_out[PSW_V:PSW_C] | mask;
			if (flag_clr)
				psw_out[PSW_V:PSW_C] <= psw_out[PSW_V:PSW_C] & ~mask;
			if (pri_write && (pri_val < pri_cur))
				psw_out[PSW_PRI_HI:PSW_PRI_LO] <= pri_val;	// Lower only
			psw_out[PSW_SLP] <= halt;	// Sleeping while at breakpoint
		end
	end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

module control_unit import cu_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int CNT_W  = 3
) (
	input  wire              clock,
	input  wire              cpucycle_rst,
	input  wire [DATA_W-1:0] pc,
	input  wire [DATA_W-1:0] brkpnt,
	input  wire [6:0]        op,
	input  wire [3:0]        cond_c,
	input  wire [CNT_W-1:0]  true_cnt,
	input  wire [CNT_W-1:0]  false_cnt,
	input  wire [2:0]        pr,
	input  wire [4:0]        pswb,
	input  wire [2:0]        dst,
	input  wire [2:0]        srccon,
	input  wire              wb,
	input  wire              rc,
	input  wire [DATA_W-1:0] psw_in,
	output logic [DATA_W-1:0] enables,
	output logic [6:0]       data_bus_ctrl,
	output logic [6:0]       addr_bus_ctrl,
	output logic [1:0]       psw_bus_ctrl,
	output logic             s_bus_ctrl,
	output logic             sxt_bus_ctrl,
	output logic [4:0]       sxt_bit_num,
	output logic             psw_update,
	output logic [5:0]       alu_op,
	output logic [4:0]       dbus_rnum_dst,
	output logic [4:0]       dbus_rnum_src,
	output logic [4:0]       alu_rnum_dst,
	output logic [4:0]       alu_rnum_src,
	output logic [4:0]       addr_rnum_src,
	output logic [DATA_W-1:0] psw_out,
	output logic [3:0]       cycle_step
);

	logic       halt;	// PC sits on the breakpoint
	logic       cycle_restart;
	logic       cond_true;
	logic [3:0] cond_code;
	logic       instr_active;
	logic       cex_load;
	logic       flag_set;
	logic       flag_clr;
	logic       pri_write;
	logic       psw_reload;
	logic [4:0] mask;
	logic [2:0] pri_val;
	logic [4:0] flags;	// Condition flags incl. SLP slot

	assign halt  = (pc == brkpnt);
	assign flags = psw_out[PSW_V:PSW_C];

	cycle_sequencer #(.DATA_W(DATA_W)) u_seq (
		.clock, .cpucycle_rst, .cycle_restart, .halt, .cycle_step
	);

	cond_eval u_cond (
		.cond_code, .flags, .cond_true
	);

	cex_tracker #(.CNT_W(CNT_W)) u_cex (
		.clock, .cpucycle_rst, .cycle_step, .cex_load, .cond_true,
		.true_cnt, .false_cnt, .instr_active
	);

	exec_ctrl #(.DATA_W(DATA_W)) u_exec (
		.clock, .cpucycle_rst, .cycle_step, .halt, .op, .cond_c, .pr, .pswb,
		.dst, .srccon, .wb, .rc, .instr_active, .cond_true,
		.cond_code, .cycle_restart, .cex_load, .flag_set, .flag_clr, .pri_write,
		.psw_reload, .mask, .pri_val,
		.enables, .data_bus_ctrl, .addr_bus_ctrl, .psw_bus_ctrl, .s_bus_ctrl,
		.sxt_bus_ctrl, .sxt_bit_num, .psw_update, .alu_op,
		.dbus_rnum_dst, .dbus_rnum_src, .alu_rnum_dst, .alu_rnum_src, .addr_rnum_src
	);

	psw_reg #(.DATA_W(DATA_W)) u_psw (
		.clock, .cpucycle_rst, .halt, .psw_in, .psw_reload, .flag_set, .flag_clr,
		.mask, .pri_write, .pri_val, .psw_out
	);

endmodule

`default_nettype wire

//--- verif/tb_control_unit.sv
`default_nettype none

module tb_control_unit import cu_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 20;	// Clocks allowed for any wait
	localparam int NFIELDS    = 28;	// Columns per stimulus line

	logic        clock;
	logic        cpucycle_rst;
	logic [15:0] pc;
	logic [15:0] brkpnt;
	logic [6:0]  op;
	logic [3:0]  cond_c;
	logic [2:0]  true_cnt;
	logic [2:0]  false_cnt;
	logic [2:0]  pr;
	logic [4:0]  pswb;
	logic [2:0]  dst;
	logic [2:0]  srccon;
	logic        wb;
	logic        rc;
	logic [15:0] psw_in;
	logic [15:0] enables;
	logic [6:0]  data_bus_ctrl;
	logic [6:0]  addr_bus_ctrl;
	logic [1:0]  psw_bus_ctrl;
	logic        s_bus_ctrl;
	logic        sxt_bus_ctrl;
	logic [4:0]  sxt_bit_num;
	logic        psw_update;
	logic [5:0]  alu_op;
	logic [4:0]  dbus_rnum_dst;
	logic [4:0]  dbus_rnum_src;
	logic [4:0]  alu_rnum_dst;
	logic [4:0]  alu_rnum_src;
	logic [4:0]  addr_rnum_src;
	logic [15:0] psw_out;
	logic [3:0]  cycle_step;

	// One stimulus line
	string       tname;
	string       line;
	logic [6:0]  f_op;
	logic [3:0]  f_cc;
	logic [2:0]  f_tc;
	logic [2:0]  f_fc;
	logic [2:0]  f_pr;
	logic [4:0]  f_pswb;
	logic [2:0]  f_dst;
	logic [2:0]  f_src;
	logic        f_wb;
	logic        f_rc;
	logic [15:0] f_pc;
	logic [15:0] f_brk;
	logic [15:0] f_psw_in;
	logic [3:0]  f_step;
	logic [15:0] e_en;
	logic [6:0]  e_dbus;
	logic [6:0]  e_abus;
	logic [1:0]  e_pbus;
	logic [4:0]  e_sxtb;
	logic        e_upd;
	logic [5:0]  e_alu;
	logic [4:0]  e_ddst;
	logic [4:0]  e_dsrc;
	logic [4:0]  e_adst;
	logic [4:0]  e_asrc;
	logic [4:0]  e_arsrc;
	logic [15:0] e_psw;

	logic [15:0] prev_psw;	// PSW expected once the last instruction settled
	integer      seed;
	integer      fd;
	int          n;
	int          errors;
	int          test_err;
	int          tests;
	int          failed;
	int          lines_run;	// Stimulus lines that made it through parsing

	control_unit #(.DATA_W(16), .CNT_W(3)) u_dut (
		.clock, .cpucycle_rst, .pc, .brkpnt, .op, .cond_c, .true_cnt, .false_cnt,
		.pr, .pswb, .dst, .srccon, .wb, .rc, .psw_in,
		.enables, .data_bus_ctrl, .addr_bus_ctrl, .psw_bus_ctrl, .s_bus_ctrl,
		.sxt_bus_ctrl, .sxt_bit_num, .psw_update, .alu_op,
		.dbus_rnum_dst, .dbus_rnum_src, .alu_rnum_dst, .alu_rnum_src, .addr_rnum_src,
		.psw_out, .cycle_step
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;	// 100 ns period
	end

	task automatic check_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		if (exp !== act)
		begin
			$display("mismatch %s %s: expected %h, actual %h", tname, what, exp, act);
			errors++;
			test_err++;
		end
	endtask

	// Steps a clock at a time until the step shows up
	task automatic wait_for_step(input logic [3:0] target);
		int cnt;
		cnt = 0;
		while (cycle_step !== target && cnt < WAIT_LIMIT)
		begin
			@(posedge clock);
			#5;
			cnt++;
		end
		if (cycle_step !== target)
		begin
			$display("timeout in test %s: cycle_step never reached %0d", tname, target);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_words();
		check_value("enables", e_en, enables);
		check_value("data_bus_ctrl", 16'(e_dbus), 16'(data_bus_ctrl));
		check_value("addr_bus_ctrl", 16'(e_abus), 16'(addr_bus_ctrl));
		check_value("psw_bus_ctrl", 16'(e_pbus), 16'(psw_bus_ctrl));
		check_value("sxt_bit_num", 16'(e_sxtb), 16'(sxt_bit_num));
		check_value("sxt_bus_ctrl", 16'(e_en[EN_SXT]), 16'(sxt_bus_ctrl));	// On with SXT
		check_value("s_bus_ctrl", 16'(e_en[EN_SXT]), 16'(s_bus_ctrl));	// Offset path
		check_value("psw_update", 16'(e_upd), 16'(psw_update));
		check_value("alu_op", 16'(e_alu), 16'(alu_op));
		check_value("dbus_rnum_dst", 16'(e_ddst), 16'(dbus_rnum_dst));
		check_value("dbus_rnum_src", 16'(e_dsrc), 16'(dbus_rnum_src));
		check_value("alu_rnum_dst", 16'(e_adst), 16'(alu_rnum_dst));
		check_value("alu_rnum_src", 16'(e_asrc), 16'(alu_rnum_src));
		check_value("addr_rnum_src", 16'(e_arsrc), 16'(addr_rnum_src));
	endtask

	// Fields that the opcode ignores get random values
	task automatic drive_fields();
		logic no_regs;
		no_regs = (f_op <= OP_BRA) || f_op == OP_SETPRI || f_op == OP_SETCC ||
			f_op == OP_CLRCC || f_op == OP_CEX;
		op     = f_op;
		wb     = f_wb;
		rc     = f_rc;
		pc     = f_pc;
		brkpnt = f_brk;
		dst    = no_regs ? 3'($random(seed)) : f_dst;
		srccon = no_regs ? 3'($random(seed)) : f_src;
		pswb   = (f_op == OP_SETCC || f_op == OP_CLRCC) ? f_pswb : 5'($random(seed));
		pr     = (f_op == OP_SETPRI) ? f_pr : 3'($random(seed));
		cond_c    = (f_op == OP_CEX) ? f_cc : 4'($random(seed));
		true_cnt  = (f_op == OP_CEX) ? f_tc : 3'($random(seed));
		false_cnt = (f_op == OP_CEX) ? f_fc : 3'($random(seed));
	endtask

	// New fields go in at fetch, so each line is exactly one instruction
	task automatic run_line();
		logic [3:0] held;
		wait_for_step(CYC_FETCH);
		drive_fields();
		@(posedge clock);
		#5;
		psw_in = f_psw_in;	// Flags this instruction's ALU step returns
		if (f_step == 4'd0)
		begin
			check_words();	// Halted outputs stay idle
			check_value("psw_out", e_psw, psw_out);
			held = cycle_step;
			for (int k = 0; k < 4; k++)
			begin
				@(posedge clock);
				#5;
				check_value("frozen cycle_step", 16'(held), 16'(cycle_step));
			end
			pc = ~f_brk;	// Leave the breakpoint
			prev_psw = e_psw & ~(16'h0001 << PSW_SLP);
		end
		else
		begin
			check_value("psw_out after previous", prev_psw, psw_out);
			if (f_step != CYC_FETCH)
			begin
				wait_for_step(f_step);
				@(posedge clock);
				#5;
			end
			check_words();
			prev_psw = e_psw;
		end
	endtask

	initial
	begin
		seed = 12;
		errors = 0;
		tests = 0;
		failed = 0;
		lines_run = 0;
		cpucycle_rst = 1'b1;
		pc = 16'h0000;
		brkpnt = 16'hFFFF;
		op = OP_MOV;
		cond_c = 4'd0;
		true_cnt = 3'd0;
		false_cnt = 3'd0;
		pr = 3'd0;
		pswb = 5'd0;
		dst = 3'd0;
		srccon = 3'd0;
		wb = 1'b0;
		rc = 1'b0;
		psw_in = 16'h0000;
		repeat (8) @(posedge clock);
		#5;
		cpucycle_rst = 1'b0;

		// Idle words straight out of reset
		tname = "reset";
		test_err = 0;
		{e_en, e_dbus, e_abus, e_pbus, e_sxtb, e_upd} = {16'h0, 7'h7F, 7'h7F, 2'b11, 5'h0, 1'b0};
		{e_alu, e_ddst, e_dsrc, e_adst, e_asrc, e_arsrc} = '0;
		check_words();
		check_value("psw_out", PSW_RESET, psw_out);
		check_value("cycle_step", 16'(CYC_FETCH), 16'(cycle_step));
		prev_psw = PSW_RESET;
		tests++;
		failed += (test_err != 0);
		$display("test %-10s %s", tname, (test_err == 0) ? "ok" : "failed");

		fd = $fopen("verif/cu_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file verif/cu_stim.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				if ($fgets(line, fd) == 0)
					break;
				if (line.len() == 0 || line.getc(0) == "#")
					continue;	// Column notes
				n = $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tname, f_op, f_cc, f_tc, f_fc, f_pr, f_pswb, f_dst, f_src, f_wb, f_rc,
					f_pc, f_brk, f_psw_in, f_step, e_en, e_dbus, e_abus, e_pbus, e_sxtb,
					e_upd, e_alu, e_ddst, e_dsrc, e_adst, e_asrc, e_arsrc, e_psw);
				if (n <= 0)
					continue;	// Blank line
				if (n != NFIELDS)
				begin
					$display("stimulus line %s is malformed, only %0d fields read", tname, n);
					errors++;
					continue;
				end
				test_err = 0;
				run_line();
				lines_run++;
				tests++;
				failed += (test_err != 0);
				$display("test %-10s %s", tname, (test_err == 0) ? "ok" : "failed");
			end
			$fclose(fd);
			if (lines_run == 0)
			begin
				$display("the stimulus file holds no test lines");
				errors++;
			end
		end

		// PSW of the last line lands during the next fetch
		tname = "final_psw";
		test_err = 0;
		wait_for_step(CYC_FETCH);
		@(posedge clock);
		#5;
		check_value("psw_out after previous", prev_psw, psw_out);
		tests++;
		failed += (test_err != 0);
		$display("test %-10s %s", tname, (test_err == 0) ? "ok" : "failed");

		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
logic/cu_pkg.sv
logic/cond_eval.sv
logic/cex_tracker.sv
logic/cycle_sequencer.sv
logic/exec_ctrl.sv
logic/psw_reg.sv
logic/control_unit.sv
verif/tb_control_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_control_unit -f vlog.f -o tb_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "Result: PASSED" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/cu_stim.txt
# name op cc tc fc pr pswb dst src wb rc pc brk psw_in step (0 = breakpoint hold)
# expect: en dbus abus pbus sxtb upd alu ddst dsrc adst asrc arsrc psw
fetch_mar 09 0 0 0 0 00 1 2 0 0 0000 ffff 60e0 1 0000 7f 08 3 00 0 00 00 00 00 00 07 60e0
fetch_pc 09 0 0 0 0 00 1 2 0 0 0000 ffff 60e0 2 8000 19 7f 3 00 0 00 07 00 07 0a 00 60e0
fetch_ir 09 0 0 0 0 00 1 2 0 0 0000 ffff 60e0 3 0000 02 7f 3 00 0 00 00 00 00 00 00 60e0
decode 09 0 0 0 0 00 1 2 0 0 0000 ffff 60e0 4 4000 7f 7f 3 00 0 00 00 00 00 00 00 60e0
add 09 0 0 0 0 00 1 2 0 0 0000 ffff 60e3 5 8000 19 7f 0 00 1 00 01 00 01 02 00 60e3
bis_rc 14 0 0 0 0 00 3 4 1 1 0000 ffff 60e4 5 8000 59 7f 0 00 1 17 03 00 03 0c 00 60e4
alu_0a 0a 0 0 0 0 00 6 0 1 0 0000 ffff 60f0 5 8000 59 7f 0 00 1 03 06 00 06 00 00 60f0
sra 17 0 0 0 0 00 2 5 0 0 0000 ffff 60e2 5 8000 19 7f 0 00 1 1c 02 00 02 05 00 60e2
rrc 18 0 0 0 0 00 7 3 1 1 0000 ffff 60e9 5 8000 59 7f 0 00 1 1f 07 00 07 0b 00 60e1
beq_n 01 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60e1
bne_t 02 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e1
bc_t 03 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e1
bnc_n 04 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60e1
bn_n 05 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60e1
bge_t 06 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e1
blt_n 07 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60e1
bra_t 08 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e1
setcc 1e 0 0 0 0 16 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60f7
beq_t 01 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60f7
blt_n2 07 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60f7
bra_n 08 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60f7
clrcc 1f 0 0 0 0 12 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60e5
bn_t 05 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e5
blt_t 07 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 a000 19 7f 3 0a 0 00 07 00 07 00 00 60e5
setpri_5 1c 0 0 0 5 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60a5
setpri_6 1c 0 0 0 6 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 60a5
setpri_2 1c 0 0 0 2 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 6045
mov 15 0 0 0 0 00 4 6 1 0 0000 ffff 0000 5 0000 49 7f 3 00 0 00 04 06 00 00 00 6045
swap_1 16 0 0 0 0 00 2 3 0 0 0000 ffff 0000 5 0000 09 7f 3 00 0 00 10 03 00 00 00 6045
swap_2 16 0 0 0 0 00 2 3 0 0 0000 ffff 0000 6 0000 09 7f 3 00 0 00 03 02 00 00 00 6045
swap_3 16 0 0 0 0 00 2 3 0 0 0000 ffff 0000 7 0000 09 7f 3 00 0 00 02 10 00 00 00 6045
bl_lr 00 0 0 0 0 00 0 0 0 0 0000 ffff 0000 5 0000 09 7f 3 00 0 00 05 07 00 00 00 6045
bl_pc 00 0 0 0 0 00 0 0 0 0 0000 ffff 0000 6 a000 19 7f 3 0d 0 00 07 00 07 00 00 6045
cex 20 4 2 1 0 00 0 0 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 6045
cex_i1 15 0 0 0 0 00 1 2 0 0 0000 ffff 0000 4 4000 7f 7f 3 00 0 00 00 00 00 00 00 6045
cex_i2 15 0 0 0 0 00 3 4 0 0 0000 ffff 0000 5 0000 09 7f 3 00 0 00 03 04 00 00 00 6045
cex_i3 15 0 0 0 0 00 5 6 0 0 0000 ffff 0000 5 0000 7f 7f 3 00 0 00 00 00 00 00 00 6045
cex_done 15 0 0 0 0 00 1 1 0 0 0000 ffff 0000 5 0000 09 7f 3 00 0 00 01 01 00 00 00 6045
brkpt 15 0 0 0 0 00 1 1 0 0 0040 0040 0000 0 0000 7f 7f 3 00 0 00 00 00 00 00 00 604d
resume 09 0 0 0 0 00 1 1 0 0 0000 ffff 60e0 5 8000 19 7f 0 00 1 00 01 00 01 01 00 60e0
